/* design/aznable_pkg.sv */
`default_nettype none

package aznable_pkg;

	// Bus and memory widths
	typedef logic [15:0] addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [23:0] dn_addr_t;
	typedef logic [7:0] dn_index_t;
	typedef logic [14:0] prog_addr_t;
	typedef logic [13:0] work_addr_t;
	typedef logic [15:0] ms_count_t;

	// One CPU bus cycle, both strobes last a single clock
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic rd;
		logic wr;
	} cpu_req_t;

	// One byte from the ROM loader
	typedef struct packed {
		dn_addr_t addr;
		byte_t data;
		dn_index_t index;
		logic wr;
	} dn_req_t;

	// Raw input words from the host framework
	typedef struct packed {
		logic [32:0] timestamp;
		logic [191:0] joystick;
		logic [47:0] paddle;
		logic [10:0] ps2_key;
	} hw_inputs_t;

	typedef enum logic [3:0] {
		REG_PROG,
		REG_TIMESTAMP,
		REG_TIMER,
		REG_JOYSTICK,
		REG_ANALOG,
		REG_PADDLE,
		REG_SPINNER,
		REG_PS2_KEY,
		REG_MOUSE,
		REG_PAUSE,
		REG_MENU,
		REG_WORK,
		REG_NONE
	} region_t;

	// Memory map, each window ends where the next one starts
	localparam addr_t MAP_TIMESTAMP_START = 16'h8002;
	localparam addr_t MAP_TIMER_START = 16'h802A;
	localparam addr_t MAP_JOYSTICK_START = 16'h803A;
	localparam addr_t MAP_ANALOG_START = 16'h80FA;
	localparam addr_t MAP_PADDLE_START = 16'h81BA;
	localparam addr_t MAP_SPINNER_START = 16'h81EA;
	localparam addr_t MAP_PS2_KEY_START = 16'h824A;
	localparam addr_t MAP_MOUSE_START = 16'h8256;
	localparam addr_t MAP_MOUSE_END = 16'h8286;
	localparam addr_t MAP_SYSTEMPAUSE = 16'h82B6;
	localparam addr_t MAP_SYSTEMMENU = 16'h82B7;
	localparam addr_t MAP_WORK_START = 16'hC000;

	localparam dn_index_t DN_INDEX_PROG = 8'd0;

	// 24 MHz clocks per millisecond
	localparam int unsigned MS_PRESCALE = 24000;

endpackage

`default_nettype wire

/* design/bus_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
	input wire clk_24,
	input wire reset,
	input wire aznable_pkg::cpu_req_t cpu_req,
	output aznable_pkg::region_t region,
	input wire aznable_pkg::byte_t prog_rdata,
	input wire prog_rvalid,
	input wire aznable_pkg::byte_t work_rdata,
	input wire aznable_pkg::byte_t io_rdata,
	input wire aznable_pkg::byte_t ctl_rdata,
	output aznable_pkg::byte_t cpu_rdata,
	output logic cpu_rvalid
);

	import aznable_pkg::*;

	logic rd_valid;
	region_t rd_region;

	function automatic logic in_window(input addr_t a, input addr_t lo, input addr_t hi);
		return (a >= lo) && (a < hi);
	endfunction

	// Address decode
	always_comb
	begin
		if (cpu_req.addr[15] == 1'b0)
			region = REG_PROG;
		else if (cpu_req.addr >= MAP_WORK_START)
			region = REG_WORK;
		else if (in_window(cpu_req.addr, MAP_TIMESTAMP_START, MAP_TIMER_START))
			region = REG_TIMESTAMP;
		else if (in_window(cpu_req.addr, MAP_TIMER_START, MAP_JOYSTICK_START))
			region = REG_TIMER;
		else if (in_window(cpu_req.addr, MAP_JOYSTICK_START, MAP_ANALOG_START))
			region = REG_JOYSTICK;
		else if (in_window(cpu_req.addr, MAP_ANALOG_START, MAP_PADDLE_START))
			region = REG_ANALOG;
		else if (in_window(cpu_req.addr, MAP_PADDLE_START, MAP_SPINNER_START))
			region = REG_PADDLE;
		else if (in_window(cpu_req.addr, MAP_SPINNER_START, MAP_PS2_KEY_START))
			region = REG_SPINNER;
		else if (in_window(cpu_req.addr, MAP_PS2_KEY_START, MAP_MOUSE_START))
			region = REG_PS2_KEY;
		else if (in_window(cpu_req.addr, MAP_MOUSE_START, MAP_MOUSE_END))
			region = REG_MOUSE;
		else if (cpu_req.addr == MAP_SYSTEMPAUSE)
			region = REG_PAUSE;
		else if (cpu_req.addr == MAP_SYSTEMMENU)
			region = REG_MENU;
		else
			region = REG_NONE;
	end

	// Non-program reads always answer on the next cycle
	always_ff @(posedge clk_24)
	begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= cpu_req.rd && (region != REG_PROG);
	end

	always_ff @(posedge clk_24)
	begin
		if (cpu_req.rd)
			rd_region <= region;
	end

	assign cpu_rvalid = rd_valid || prog_rvalid;

	// Select the peer that answered
	always_comb
	begin
		if (prog_rvalid)
			cpu_rdata = prog_rdata;
		else
		begin
			case (rd_region)
				REG_WORK: cpu_rdata = work_rdata;
				REG_TIMESTAMP, REG_JOYSTICK, REG_PADDLE, REG_PS2_KEY: cpu_rdata = io_rdata;
				REG_TIMER, REG_PAUSE, REG_MENU: cpu_rdata = ctl_rdata;
				default: cpu_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/prog_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_mem_arbiter (
	input wire clk_24,
	input wire reset,
	input wire aznable_pkg::cpu_req_t cpu_req,
	input wire aznable_pkg::region_t region,
	input wire aznable_pkg::dn_req_t dn_req,
	output aznable_pkg::byte_t prog_rdata,
	output logic prog_rvalid
);

	import aznable_pkg::*;

	// 32 KB program memory, single port
	byte_t mem [0:(1 << $bits(prog_addr_t)) - 1];

	logic dn_wr;
	logic cpu_rd;
	logic rd_fire;
	logic pend_valid;
	prog_addr_t pend_addr;
	prog_addr_t cpu_addr;
	prog_addr_t dn_addr;

	assign dn_wr = dn_req.wr && (dn_req.index == DN_INDEX_PROG);
	assign cpu_rd = cpu_req.rd && (region == REG_PROG);
	assign cpu_addr = cpu_req.addr[$bits(prog_addr_t) - 1:0];
	assign dn_addr = dn_req.addr[$bits(prog_addr_t) - 1:0];

	// The loader owns the port whenever it writes
	assign rd_fire = !dn_wr && (pend_valid || cpu_rd);

	always_ff @(posedge clk_24)
	begin
		if (dn_wr)
			mem[dn_addr] <= dn_req.data;
		else if (pend_valid)
			prog_rdata <= mem[pend_addr];
		else if (cpu_rd)
			prog_rdata <= mem[cpu_addr];
	end

	// A read that lost the port is parked for one cycle
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			pend_valid <= 1'b0;
			prog_rvalid <= 1'b0;
		end
		else
		begin
			prog_rvalid <= rd_fire;
			if (dn_wr && cpu_rd)
				pend_valid <= 1'b1;
			else if (rd_fire)
				pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (dn_wr && cpu_rd)
			pend_addr <= cpu_addr;
	end

endmodule

`default_nettype wire

/* design/work_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module work_ram (
	input wire clk_24,
	input wire aznable_pkg::cpu_req_t cpu_req,
	input wire aznable_pkg::region_t region,
	output aznable_pkg::byte_t work_rdata
);

	import aznable_pkg::*;

	// 16 KB from C000h up
	byte_t mem [0:(1 << $bits(work_addr_t)) - 1];

	work_addr_t idx;
	logic sel;

	assign idx = cpu_req.addr[$bits(work_addr_t) - 1:0];
	assign sel = (region == REG_WORK);

	always_ff @(posedge clk_24)
	begin
		if (sel && cpu_req.wr)
			mem[idx] <= cpu_req.wdata;
		// Strobes never overlap, so the read sees settled contents
		if (sel && cpu_req.rd)
			work_rdata <= mem[idx];
	end

endmodule

`default_nettype wire

/* design/io_window.sv */
`timescale 1ns/1ps
`default_nettype none

module io_window (
	input wire clk_24,
	input wire aznable_pkg::cpu_req_t cpu_req,
	input wire aznable_pkg::region_t region,
	input wire aznable_pkg::hw_inputs_t hw_inputs,
	output aznable_pkg::byte_t io_rdata
);

	import aznable_pkg::*;

	// Byte offsets into each window
	addr_t ts_off;
	addr_t joy_off;
	addr_t pad_off;
	addr_t key_off;

	assign ts_off = cpu_req.addr - MAP_TIMESTAMP_START;
	assign joy_off = cpu_req.addr - MAP_JOYSTICK_START;
	assign pad_off = cpu_req.addr - MAP_PADDLE_START;
	assign key_off = cpu_req.addr - MAP_PS2_KEY_START;

	// Words are zero extended, so bytes past the top read as zero
	function automatic byte_t pick_byte(input logic [255:0] word, input logic [4:0] k);
		return word[{k, 3'b000} +: 8];
	endfunction

	always_ff @(posedge clk_24)
	begin
		if (cpu_req.rd)
		begin
			case (region)
				REG_TIMESTAMP:
					io_rdata <= pick_byte(256'(hw_inputs.timestamp), {2'b00, ts_off[2:0]});
				REG_JOYSTICK:
					io_rdata <= pick_byte(256'(hw_inputs.joystick), joy_off[4:0]);
				REG_PADDLE:
					io_rdata <= pick_byte(256'(hw_inputs.paddle), {2'b00, pad_off[2:0]});
				REG_PS2_KEY:
					io_rdata <= pick_byte(256'(hw_inputs.ps2_key), {4'b0000, key_off[0]});
				default:
					io_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/system_control.sv */
`timescale 1ns/1ps
`default_nettype none

module system_control (
	input wire clk_24,
	input wire reset,
	input wire aznable_pkg::cpu_req_t cpu_req,
	input wire aznable_pkg::region_t region,
	input wire pause,
	input wire menu,
	output aznable_pkg::byte_t ctl_rdata,
	output logic pause_system
);

	import aznable_pkg::*;

	typedef logic [$clog2(MS_PRESCALE) - 1:0] prescale_t;

	prescale_t prescale;
	ms_count_t ms_count;
	addr_t timer_off;
	logic timer_clear;
	logic pause_trigger;
	logic menu_trigger;

	assign timer_off = cpu_req.addr - MAP_TIMER_START;
	assign timer_clear = cpu_req.wr && (region == REG_TIMER);

	// Millisecond timer, any write restarts it from zero
	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clear)
		begin
			prescale <= '0;
			ms_count <= '0;
		end
		else if (prescale == prescale_t'(MS_PRESCALE - 1))
		begin
			prescale <= '0;
			ms_count <= ms_count + 16'd1;
		end
		else
			prescale <= prescale + 1'b1;
	end

	// Pause input clears the trigger even during a write
	always_ff @(posedge clk_24)
	begin
		if (reset || pause)
			pause_trigger <= 1'b0;
		else if (cpu_req.wr && (region == REG_PAUSE))
			pause_trigger <= 1'b1;
	end

	// Menu write acknowledges, and wins over a new request
	always_ff @(posedge clk_24)
	begin
		if (reset || (cpu_req.wr && (region == REG_MENU)))
			menu_trigger <= 1'b0;
		else if (menu)
			menu_trigger <= 1'b1;
	end

	assign pause_system = pause || pause_trigger;

	always_ff @(posedge clk_24)
	begin
		if (cpu_req.rd)
		begin
			case (region)
				REG_TIMER: ctl_rdata <= timer_off[0] ? ms_count[15:8] : ms_count[7:0];
				REG_MENU: ctl_rdata <= {8{menu_trigger}};
				default: ctl_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/aznable_system.sv */
`timescale 1ns/1ps
`default_nettype none

module aznable_system (
	input wire clk_24,
	input wire reset,
	input wire aznable_pkg::cpu_req_t cpu_req,
	output aznable_pkg::byte_t cpu_rdata,
	output logic cpu_rvalid,
	input wire aznable_pkg::dn_req_t dn_req,
	input wire aznable_pkg::hw_inputs_t hw_inputs,
	input wire pause,
	input wire menu,
	output logic pause_system
);

	import aznable_pkg::*;

	region_t region;
	byte_t prog_rdata;
	logic prog_rvalid;
	byte_t work_rdata;
	byte_t io_rdata;
	byte_t ctl_rdata;

	// Decode and read return path
	bus_fabric u_fabric (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_req(cpu_req),
		.region(region),
		.prog_rdata(prog_rdata),
		.prog_rvalid(prog_rvalid),
		.work_rdata(work_rdata),
		.io_rdata(io_rdata),
		.ctl_rdata(ctl_rdata),
		.cpu_rdata(cpu_rdata),
		.cpu_rvalid(cpu_rvalid)
	);

	// Program memory shared with the loader
	prog_mem_arbiter u_prog (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_req(cpu_req),
		.region(region),
		.dn_req(dn_req),
		.prog_rdata(prog_rdata),
		.prog_rvalid(prog_rvalid)
	);

	work_ram u_work (
		.clk_24(clk_24),
		.cpu_req(cpu_req),
		.region(region),
		.work_rdata(work_rdata)
	);

	io_window u_io (
		.clk_24(clk_24),
		.cpu_req(cpu_req),
		.region(region),
		.hw_inputs(hw_inputs),
		.io_rdata(io_rdata)
	);

	system_control u_ctl (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_req(cpu_req),
		.region(region),
		.pause(pause),
		.menu(menu),
		.ctl_rdata(ctl_rdata),
		.pause_system(pause_system)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk_24,
	output logic reset
);

	// 4 ns period
	initial
	begin
		clk_24 = 1'b0;
		forever #2 clk_24 = ~clk_24;
	end

	// Held over three rising edges, released on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk_24);
		@(negedge clk_24);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/aznable_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module aznable_asserts (
	input wire clk_24,
	input wire reset,
	input wire aznable_pkg::cpu_req_t cpu_req,
	input wire cpu_rvalid,
	input wire pause,
	input wire pause_system
);

	import aznable_pkg::*;

	logic rd_d1;
	logic rd_d2;
	logic rvalid_d1;
	logic outstanding;
	logic trigger;

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			rd_d1 <= 1'b0;
			rd_d2 <= 1'b0;
			rvalid_d1 <= 1'b0;
			outstanding <= 1'b0;
			trigger <= 1'b0;
		end
		else
		begin
			rd_d1 <= cpu_req.rd;
			rd_d2 <= rd_d1;
			rvalid_d1 <= cpu_rvalid;
			if (cpu_req.rd)
				outstanding <= 1'b1;
			else if (cpu_rvalid)
				outstanding <= 1'b0;
			// Expected pause trigger, the pause input clears it first
			if (pause)
				trigger <= 1'b0;
			else if (cpu_req.wr && (cpu_req.addr == MAP_SYSTEMPAUSE))
				trigger <= 1'b1;
		end
	end

	a_resp_window: assert property (@(posedge clk_24) disable iff (reset)
		rd_d2 |-> (rvalid_d1 || cpu_rvalid))
		else $error("no cpu_rvalid within two cycles of a read strobe");

	a_no_spurious: assert property (@(posedge clk_24) disable iff (reset)
		cpu_rvalid |-> outstanding)
		else $error("cpu_rvalid without an outstanding read");

	a_pause_follow: assert property (@(posedge clk_24) disable iff (reset)
		!trigger |-> (pause_system == pause))
		else $error("pause_system differs from pause while the trigger is clear");

endmodule

bind aznable_system aznable_asserts u_asserts (
	.clk_24(clk_24),
	.reset(reset),
	.cpu_req(cpu_req),
	.cpu_rvalid(cpu_rvalid),
	.pause(pause),
	.pause_system(pause_system)
);

`default_nettype wire

/* testbench/tb_aznable.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_aznable;

	import aznable_pkg::*;

	typedef enum logic [2:0] {
		OP_DN_WRITE,
		OP_BUS_WRITE,
		OP_BUS_READ,
		OP_COLLIDE_READ,
		OP_SET_INPUTS,
		OP_CHECK_PAUSE,
		OP_WAIT
	} op_t;

	// aux is the download address of a colliding read or the length of a wait
	typedef struct packed {
		op_t op;
		addr_t addr;
		addr_t aux;
		byte_t data;
		byte_t exp;
	} entry_t;

	logic clk_24;
	logic reset;
	cpu_req_t cpu_req;
	byte_t cpu_rdata;
	logic cpu_rvalid;
	dn_req_t dn_req;
	hw_inputs_t hw_inputs;
	hw_inputs_t hw_rand;
	logic pause;
	logic menu;
	logic pause_system;

	entry_t tbl[$];
	string names[$];
	string cur_test;
	logic table_ready = 1'b0;
	logic [15:0] lfsr_state = 16'd58317;
	int checks = 0;
	int errors = 0;

	tb_clock u_clock (
		.clk_24(clk_24),
		.reset(reset)
	);

	aznable_system i_dut (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_req(cpu_req),
		.cpu_rdata(cpu_rdata),
		.cpu_rvalid(cpu_rvalid),
		.dn_req(dn_req),
		.hw_inputs(hw_inputs),
		.pause(pause),
		.menu(menu),
		.pause_system(pause_system)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic b;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			b = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (b)
				lfsr_state = lfsr_state ^ 16'hB400;
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic byte_t rand_byte();
		return byte_t'(rand_bits(8));
	endfunction

	// Byte k of a zero extended input word
	function automatic byte_t word_byte(input logic [255:0] word, input int k);
		return byte_t'(word >> (8 * k));
	endfunction

	task automatic add_entry(input string name, input op_t kind, input addr_t addr,
		input addr_t aux, input byte_t data, input byte_t exp);
		entry_t e;
		e = '{op: kind, addr: addr, aux: aux, data: data, exp: exp};
		tbl.push_back(e);
		names.push_back(name);
	endtask

	task automatic build_table();
		addr_t pa [6];
		byte_t pd [6];
		addr_t zero_addrs [9];
		logic [31:0] v;
		byte_t d;
		addr_t a;
		zero_addrs = '{MAP_ANALOG_START, MAP_ANALOG_START + 16'h40, MAP_SPINNER_START,
			MAP_SPINNER_START + 16'h10, MAP_MOUSE_START, MAP_MOUSE_END - 16'h1,
			16'h8000, 16'h8290, 16'h82B8};
		// Low nibble keeps the downloaded addresses distinct
		for (int i = 0; i < 6; i++)
		begin
			v = rand_bits(11);
			pa[i] = {1'b0, v[10:0], 4'(i)};
			pd[i] = rand_byte();
			add_entry("prog_download", OP_DN_WRITE, pa[i], 16'h0, pd[i], 8'h00);
		end
		add_entry("prog_download", OP_WAIT, 16'h0, 16'd2, 8'h00, 8'h00);
		for (int i = 0; i < 6; i++)
			add_entry("prog_readback", OP_BUS_READ, pa[i], 16'h0, 8'h00, pd[i]);
		add_entry("prog_collide", OP_COLLIDE_READ, pa[0], pa[0] ^ 16'h0008, rand_byte(), pd[0]);
		add_entry("prog_write_ignored", OP_BUS_WRITE, pa[1], 16'h0, ~pd[1], 8'h00);
		add_entry("prog_write_ignored", OP_BUS_READ, pa[1], 16'h0, 8'h00, pd[1]);
		for (int i = 0; i < 6; i++)
		begin
			v = rand_bits(14);
			a = MAP_WORK_START | addr_t'(v[13:0]);
			d = rand_byte();
			add_entry("work_ram", OP_BUS_WRITE, a, 16'h0, d, 8'h00);
			add_entry("work_ram", OP_BUS_READ, a, 16'h0, 8'h00, d);
		end
		// Random input words
		hw_rand.timestamp[31:0] = rand_bits(32);
		v = rand_bits(1);
		hw_rand.timestamp[32] = v[0];
		for (int j = 0; j < 6; j++)
			hw_rand.joystick[32 * j +: 32] = rand_bits(32);
		hw_rand.paddle[31:0] = rand_bits(32);
		v = rand_bits(16);
		hw_rand.paddle[47:32] = v[15:0];
		v = rand_bits(11);
		hw_rand.ps2_key = v[10:0];
		add_entry("io_windows", OP_SET_INPUTS, 16'h0, 16'h0, 8'h00, 8'h00);
		for (int k = 0; k < 8; k++)
			add_entry("io_windows", OP_BUS_READ, MAP_TIMESTAMP_START + addr_t'(k), 16'h0, 8'h00,
				word_byte(256'(hw_rand.timestamp), k));
		for (int k = 0; k < 32; k++)
			add_entry("io_windows", OP_BUS_READ, MAP_JOYSTICK_START + addr_t'(k), 16'h0, 8'h00,
				word_byte(256'(hw_rand.joystick), k));
		for (int k = 0; k < 8; k++)
			add_entry("io_windows", OP_BUS_READ, MAP_PADDLE_START + addr_t'(k), 16'h0, 8'h00,
				word_byte(256'(hw_rand.paddle), k));
		for (int k = 0; k < 2; k++)
			add_entry("io_windows", OP_BUS_READ, MAP_PS2_KEY_START + addr_t'(k), 16'h0, 8'h00,
				word_byte(256'(hw_rand.ps2_key), k));
		for (int k = 0; k < 9; k++)
			add_entry("unmapped_zero", OP_BUS_READ, zero_addrs[k], 16'h0, 8'h00, 8'h00);
		// Let the timer step once so that the clear has something to undo
		add_entry("timer_clear", OP_WAIT, 16'h0, 16'(MS_PRESCALE), 8'h00, 8'h00);
		add_entry("timer_clear", OP_BUS_READ, MAP_TIMER_START, 16'h0, 8'h00, 8'h01);
		add_entry("timer_clear", OP_BUS_WRITE, MAP_TIMER_START, 16'h0, rand_byte(), 8'h00);
		add_entry("timer_clear", OP_BUS_READ, MAP_TIMER_START, 16'h0, 8'h00, 8'h00);
		add_entry("timer_clear", OP_BUS_READ, MAP_TIMER_START + 16'h1, 16'h0, 8'h00, 8'h00);
		// Pause trigger set by a write and cleared by a pulse on the pause input
		add_entry("pause_trigger", OP_SET_INPUTS, 16'h0, 16'h0, 8'h00, 8'h00);
		add_entry("pause_trigger", OP_CHECK_PAUSE, 16'h0, 16'h0, 8'h00, 8'h00);
		add_entry("pause_trigger", OP_BUS_WRITE, MAP_SYSTEMPAUSE, 16'h0, 8'h01, 8'h00);
		add_entry("pause_trigger", OP_WAIT, 16'h0, 16'd3, 8'h00, 8'h00);
		add_entry("pause_trigger", OP_CHECK_PAUSE, 16'h0, 16'h0, 8'h00, 8'h01);
		add_entry("pause_trigger", OP_SET_INPUTS, 16'h0, 16'h0, 8'h01, 8'h00);
		add_entry("pause_trigger", OP_CHECK_PAUSE, 16'h0, 16'h0, 8'h00, 8'h01);
		add_entry("pause_trigger", OP_SET_INPUTS, 16'h0, 16'h0, 8'h00, 8'h00);
		add_entry("pause_trigger", OP_CHECK_PAUSE, 16'h0, 16'h0, 8'h00, 8'h00);
		add_entry("menu_trigger", OP_BUS_READ, MAP_SYSTEMMENU, 16'h0, 8'h00, 8'h00);
		add_entry("menu_trigger", OP_SET_INPUTS, 16'h0, 16'h0, 8'h02, 8'h00);
		add_entry("menu_trigger", OP_SET_INPUTS, 16'h0, 16'h0, 8'h00, 8'h00);
		add_entry("menu_trigger", OP_BUS_READ, MAP_SYSTEMMENU, 16'h0, 8'h00, 8'hFF);
		add_entry("menu_trigger", OP_BUS_WRITE, MAP_SYSTEMMENU, 16'h0, 8'h00, 8'h00);
		add_entry("menu_trigger", OP_BUS_READ, MAP_SYSTEMMENU, 16'h0, 8'h00, 8'h00);
	endtask

	task automatic check_value(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	// Every operation starts and ends on a falling edge
	task automatic run_entry(input entry_t e);
		int cycles;
		case (e.op)
			OP_DN_WRITE:
			begin
				dn_req = '{addr: dn_addr_t'(e.addr), data: e.data, index: DN_INDEX_PROG, wr: 1'b1};
				@(negedge clk_24);
				dn_req.wr = 1'b0;
				@(negedge clk_24);
			end
			OP_BUS_WRITE:
			begin
				cpu_req = '{addr: e.addr, wdata: e.data, rd: 1'b0, wr: 1'b1};
				@(negedge clk_24);
				cpu_req.wr = 1'b0;
			end
			OP_BUS_READ, OP_COLLIDE_READ:
			begin
				cpu_req = '{addr: e.addr, wdata: 8'h00, rd: 1'b1, wr: 1'b0};
				if (e.op == OP_COLLIDE_READ)
					dn_req = '{addr: dn_addr_t'(e.aux), data: e.data, index: DN_INDEX_PROG,
						wr: 1'b1};
				@(negedge clk_24);
				cpu_req.rd = 1'b0;
				dn_req.wr = 1'b0;
				cycles = 1;
				while (!cpu_rvalid && cycles < 8)
				begin
					@(negedge clk_24);
					cycles++;
				end
				if (!cpu_rvalid)
				begin
					errors++;
					$display("no read response from address %h in %s", e.addr, cur_test);
				end
				else
				begin
					check_value("read data", 16'(e.exp), 16'(cpu_rdata));
					check_value("latency", (e.op == OP_COLLIDE_READ) ? 16'd2 : 16'd1,
						16'(cycles));
				end
			end
			OP_SET_INPUTS:
			begin
				hw_inputs = hw_rand;
				pause = e.data[0];
				menu = e.data[1];
				@(negedge clk_24);
			end
			OP_CHECK_PAUSE:
				check_value("pause_system", 16'(e.exp), 16'(pause_system));
			default:
				repeat (e.aux) @(negedge clk_24);
		endcase
	endtask

	initial
	begin
		int n_pass;
		int n_fail;
		int test_err;
		n_pass = 0;
		n_fail = 0;
		test_err = 0;
		cpu_req = '0;
		dn_req = '0;
		hw_inputs = '0;
		hw_rand = '0;
		pause = 1'b0;
		menu = 1'b0;
		build_table();
		table_ready = 1'b1;
		@(negedge reset);
		@(negedge clk_24);
		for (int i = 0; i < tbl.size(); i++)
		begin
			cur_test = names[i];
			run_entry(tbl[i]);
			// A test ends where the next entry has another name
			if (i == tbl.size() - 1 || names[i + 1] != names[i])
			begin
				if (errors == test_err)
				begin
					n_pass++;
					$display("test %s: pass", cur_test);
				end
				else
				begin
					n_fail++;
					$display("test %s: fail with %0d errors", cur_test, errors - test_err);
				end
				test_err = errors;
			end
		end
		$display("%0d tests passed, %0d failed, %0d checks, %0d errors",
			n_pass, n_fail, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Watchdog allows ten cycles per entry plus the waits
	initial
	begin
		int limit;
		wait (table_ready);
		limit = tbl.size() * 10;
		for (int i = 0; i < tbl.size(); i++)
			if (tbl[i].op == OP_WAIT)
				limit += int'(tbl[i].aux);
		repeat (limit) @(posedge clk_24);
		$display("timeout, the tests did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
design/aznable_pkg.sv
design/bus_fabric.sv
design/prog_mem_arbiter.sv
design/work_ram.sv
design/io_window.sv
design/system_control.sv
design/aznable_system.sv
testbench/tb_clock.sv
testbench/aznable_asserts.sv
testbench/tb_aznable.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; pass only when the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_aznable -f vlog.f \
	&& ./obj_dir/Vtb_aznable | tee /dev/stderr | grep -q -F '*** PASSED ***' \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
